// File: Makefile
TOOL       := verilator
TOP        := tb_top
FILELIST   := project.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: axi/axi_xbar.sv
`timescale 1ns/1ps

module axi_xbar (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [axi_pkg::AXI_ID_BITS-1:0]   arid_m0,
  input  logic [axi_pkg::AXI_ADDR_BITS-1:0] araddr_m0,
  input  logic                              arvalid_m0,
  output logic                              arready_m0,
  output logic [axi_pkg::AXI_ID_BITS-1:0]   rid_m0,
  output logic [axi_pkg::AXI_DATA_BITS-1:0] rdata_m0,
  output logic [1:0]                        rresp_m0,
  output logic                              rvalid_m0,
  input  logic                              rready_m0,
  input  logic [axi_pkg::AXI_ID_BITS-1:0]   arid_m1,
  input  logic [axi_pkg::AXI_ADDR_BITS-1:0] araddr_m1,
  input  logic                              arvalid_m1,
  output logic                              arready_m1,
  output logic [axi_pkg::AXI_ID_BITS-1:0]   rid_m1,
  output logic [axi_pkg::AXI_DATA_BITS-1:0] rdata_m1,
  output logic [1:0]                        rresp_m1,
  output logic                              rvalid_m1,
  input  logic                              rready_m1,
  input  logic [axi_pkg::AXI_ID_BITS-1:0]   awid_m1,
  input  logic [axi_pkg::AXI_ADDR_BITS-1:0] awaddr_m1,
  input  logic                              awvalid_m1,
  output logic                              awready_m1,
  input  logic [axi_pkg::AXI_DATA_BITS-1:0] wdata_m1,
  input  logic [axi_pkg::AXI_STRB_BITS-1:0] wstrb_m1,
  input  logic                              wvalid_m1,
  output logic                              wready_m1,
  output logic [axi_pkg::AXI_ID_BITS-1:0]   bid_m1,
  output logic [1:0]                        bresp_m1,
  output logic                              bvalid_m1,
  input  logic                              bready_m1,
  axi_if.master                             s0,
  axi_if.master                             s1
);
  import axi_pkg::*;

  localparam int MI_BITS = AXI_IDS_BITS - AXI_ID_BITS;

  logic [1:0]               ar_hit_m0, ar_hit_m1, aw_hit;
  logic [1:0]               req_m0, req_m1, busy, sel, grant_q, ar_go;
  logic [1:0]               rd_out_q, ar_done, r_done, r_valid, r_ready;
  logic [1:0]               s0_r_hit, s1_r_hit, err_r_hit;
  logic                     aw_req, wr_out_q;
  logic                     err_rd_m0, err_rd_m1, err_wr, err_load, err_done;
  logic                     err_valid_q, err_write_q, err_master_q;
  logic [AXI_ID_BITS-1:0]   err_id_q;
  logic [AXI_ID_BITS-1:0]   r_id [2];
  logic [AXI_DATA_BITS-1:0] r_data [2];
  logic [1:0]               r_resp [2];

  // Bit 1 hits DM, bit 0 hits IM
  function automatic logic [1:0] region(input logic [AXI_ADDR_BITS-1:0] addr);
    return {addr[AXI_ADDR_BITS-1:REGION_BITS] == DM_BASE[AXI_ADDR_BITS-1:REGION_BITS],
            addr[AXI_ADDR_BITS-1:REGION_BITS] == IM_BASE[AXI_ADDR_BITS-1:REGION_BITS]};
  endfunction

  assign ar_hit_m0 = region(araddr_m0);
  assign ar_hit_m1 = region(araddr_m1);
  assign aw_hit    = region(awaddr_m1);

  // One read in flight per master, so each R source is unique
  assign req_m0 = {2{arvalid_m0 & ~rd_out_q[0]}} & ar_hit_m0;
  assign req_m1 = {2{arvalid_m1 & ~rd_out_q[1]}} & ar_hit_m1;
  assign busy   = {s1.rvalid | s1.bvalid, s0.rvalid | s0.bvalid};
  assign sel    = (req_m0 & req_m1 & grant_q) | (~req_m0 & req_m1);

  // Held off while the slave owes a response, which locks the grant
  assign s0.arvalid = ~busy[0] & (req_m0[0] | req_m1[0]);
  assign s0.arid    = sel[0] ? {MI_BITS'(1), arid_m1} : {MI_BITS'(0), arid_m0};
  assign s0.araddr  = sel[0] ? araddr_m1 : araddr_m0;
  assign s1.arvalid = ~busy[1] & (req_m0[1] | req_m1[1]);
  assign s1.arid    = sel[1] ? {MI_BITS'(1), arid_m1} : {MI_BITS'(0), arid_m0};
  assign s1.araddr  = sel[1] ? araddr_m1 : araddr_m0;
  assign ar_go      = {s1.arvalid & s1.arready, s0.arvalid & s0.arready};

  // Unmapped requests, M0 read first, then M1 read, then write
  assign err_rd_m0 = ~err_valid_q & arvalid_m0 & ~rd_out_q[0] & ~(|ar_hit_m0);
  assign err_rd_m1 = ~err_valid_q & arvalid_m1 & ~rd_out_q[1] & ~(|ar_hit_m1) & ~err_rd_m0;
  assign err_wr    = ~err_valid_q & aw_req & ~(|aw_hit) & ~err_rd_m0 & ~err_rd_m1;
  assign err_load  = err_rd_m0 | err_rd_m1 | err_wr;
  assign err_done  = err_valid_q & (err_write_q ? bready_m1 : r_ready[err_master_q]);

  assign arready_m0 = (|(ar_go & ~sel)) | err_rd_m0;
  assign arready_m1 = (|(ar_go & sel)) | err_rd_m1;
  assign ar_done    = {arvalid_m1 & arready_m1, arvalid_m0 & arready_m0};

  // Writes only come from M1, AW and W travel together
  assign aw_req     = awvalid_m1 & wvalid_m1 & ~wr_out_q;
  assign s0.awvalid = aw_req & aw_hit[0];
  assign s0.wvalid  = aw_req & aw_hit[0];
  assign s0.awid    = {MI_BITS'(1), awid_m1};
  assign s0.awaddr  = awaddr_m1;
  assign s0.wdata   = wdata_m1;
  assign s0.wstrb   = wstrb_m1;
  assign s0.bready  = bready_m1;
  assign s1.awvalid = aw_req & aw_hit[1];
  assign s1.wvalid  = aw_req & aw_hit[1];
  assign s1.awid    = {MI_BITS'(1), awid_m1};
  assign s1.awaddr  = awaddr_m1;
  assign s1.wdata   = wdata_m1;
  assign s1.wstrb   = wstrb_m1;
  assign s1.bready  = bready_m1;
  assign awready_m1 = (s0.awvalid & s0.awready) | (s1.awvalid & s1.awready) | err_wr;
  assign wready_m1  = (s0.wvalid & s0.wready) | (s1.wvalid & s1.wready) | err_wr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_q     <= 2'b00;
      rd_out_q    <= 2'b00;
      wr_out_q    <= 1'b0;
      err_valid_q <= 1'b0;
    end else begin
      grant_q     <= (grant_q & ~ar_go) | (~sel & ar_go);
      rd_out_q    <= (rd_out_q | ar_done) & ~r_done;
      wr_out_q    <= (wr_out_q | (awvalid_m1 & awready_m1)) & ~(bvalid_m1 & bready_m1);
      err_valid_q <= err_load | (err_valid_q & ~err_done);
    end
  end

  always_ff @(posedge clk) begin
    if (err_load) begin
      err_write_q  <= err_wr;
      err_master_q <= ~err_rd_m0;
      err_id_q     <= err_rd_m0 ? arid_m0 : (err_rd_m1 ? arid_m1 : awid_m1);
    end
  end

  // R goes back to the master in the upper ID bits
  assign r_ready   = {rready_m1, rready_m0};
  assign s0_r_hit  = {2{s0.rvalid}} & ((s0.rid[AXI_IDS_BITS-1:AXI_ID_BITS] != '0) ? 2'b10 : 2'b01);
  assign s1_r_hit  = {2{s1.rvalid}} & ((s1.rid[AXI_IDS_BITS-1:AXI_ID_BITS] != '0) ? 2'b10 : 2'b01);
  assign err_r_hit = {2{err_valid_q & ~err_write_q}} & (err_master_q ? 2'b10 : 2'b01);
  assign r_valid   = s0_r_hit | s1_r_hit | err_r_hit;
  assign r_done    = r_valid & r_ready;
  assign s0.rready = |(s0_r_hit & r_ready);
  assign s1.rready = |(s1_r_hit & r_ready);

  always_comb begin
    for (int m = 0; m < 2; m++) begin
      r_id[m]   = err_id_q;
      r_data[m] = '0;
      r_resp[m] = AXI_RESP_DECERR;
      if (s0_r_hit[m]) begin
        r_id[m]   = s0.rid[AXI_ID_BITS-1:0];
        r_data[m] = s0.rdata;
        r_resp[m] = s0.rresp;
      end else if (s1_r_hit[m]) begin
        r_id[m]   = s1.rid[AXI_ID_BITS-1:0];
        r_data[m] = s1.rdata;
        r_resp[m] = s1.rresp;
      end
    end
  end

  assign rvalid_m0 = r_valid[0];
  assign rid_m0    = r_id[0];
  assign rdata_m0  = r_data[0];
  assign rresp_m0  = r_resp[0];
  assign rvalid_m1 = r_valid[1];
  assign rid_m1    = r_id[1];
  assign rdata_m1  = r_data[1];
  assign rresp_m1  = r_resp[1];

  // Single write in flight, at most one B source
  assign bvalid_m1 = s0.bvalid | s1.bvalid | (err_valid_q & err_write_q);
  assign bid_m1    = s0.bvalid ? s0.bid[AXI_ID_BITS-1:0] :
                     (s1.bvalid ? s1.bid[AXI_ID_BITS-1:0] : err_id_q);
  assign bresp_m1  = s0.bvalid ? s0.bresp : (s1.bvalid ? s1.bresp : AXI_RESP_DECERR);

endmodule

// File: bench/tb_top.sv
`timescale 1ns/1ps

module tb_top;
  import axi_pkg::*;

  localparam int TIMEOUT = 64;

  logic                     clk;
  logic                     arst_n;
  logic [1:0]               arvalid;
  logic [1:0]               rready;
  logic [AXI_ID_BITS-1:0]   arid [2];
  logic [AXI_ADDR_BITS-1:0] araddr [2];
  wire  [1:0]               arready;
  wire  [1:0]               rvalid;
  wire  [AXI_ID_BITS-1:0]   rid [2];
  wire  [AXI_DATA_BITS-1:0] rdata [2];
  wire  [1:0]               rresp [2];
  logic [AXI_ID_BITS-1:0]   awid;
  logic [AXI_ADDR_BITS-1:0] awaddr;
  logic [AXI_DATA_BITS-1:0] wdata;
  logic [AXI_STRB_BITS-1:0] wstrb;
  logic                     awvalid;
  logic                     wvalid;
  logic                     bready;
  wire                      awready;
  wire                      wready;
  wire                      bvalid;
  wire  [AXI_ID_BITS-1:0]   bid;
  wire  [1:0]               bresp;
  integer                   seed;

  top #(.IM_WORDS(1024), .DM_WORDS(1024)) u_top (
    .clk        (clk),
    .arst_n     (arst_n),
    .arid_m0    (arid[0]),
    .araddr_m0  (araddr[0]),
    .arvalid_m0 (arvalid[0]),
    .arready_m0 (arready[0]),
    .rid_m0     (rid[0]),
    .rdata_m0   (rdata[0]),
    .rresp_m0   (rresp[0]),
    .rvalid_m0  (rvalid[0]),
    .rready_m0  (rready[0]),
    .arid_m1    (arid[1]),
    .araddr_m1  (araddr[1]),
    .arvalid_m1 (arvalid[1]),
    .arready_m1 (arready[1]),
    .rid_m1     (rid[1]),
    .rdata_m1   (rdata[1]),
    .rresp_m1   (rresp[1]),
    .rvalid_m1  (rvalid[1]),
    .rready_m1  (rready[1]),
    .awid_m1    (awid),
    .awaddr_m1  (awaddr),
    .awvalid_m1 (awvalid),
    .awready_m1 (awready),
    .wdata_m1   (wdata),
    .wstrb_m1   (wstrb),
    .wvalid_m1  (wvalid),
    .wready_m1  (wready),
    .bid_m1     (bid),
    .bresp_m1   (bresp),
    .bvalid_m1  (bvalid),
    .bready_m1  (bready)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic timed_out(input string what);
    $display("Timeout while waiting for %s", what);
    abort_run();
  endtask

  task automatic check_data(input string name, input logic [AXI_DATA_BITS-1:0] exp,
                            input logic [AXI_DATA_BITS-1:0] got);
    if (got !== exp) begin
      $display("Error %s expected %h got %h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_id(input string name, input logic [AXI_ID_BITS-1:0] exp,
                          input logic [AXI_ID_BITS-1:0] got);
    if (got !== exp) begin
      $display("Error %s expected %h got %h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] got);
    if (got !== exp) begin
      $display("Error %s expected %h got %h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("Error %s expected %h got %h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic compare_r(input int m, input logic [AXI_ID_BITS-1:0] id,
                           input logic [AXI_DATA_BITS-1:0] data, input logic [1:0] resp);
    check_bit($sformatf("rvalid_m%0d", m), 1'b1, rvalid[m]);
    check_id($sformatf("rid_m%0d", m), id, rid[m]);
    check_data($sformatf("rdata_m%0d", m), data, rdata[m]);
    check_resp($sformatf("rresp_m%0d", m), resp, rresp[m]);
  endtask

  task automatic compare_b(input logic [AXI_ID_BITS-1:0] id, input logic [1:0] resp);
    check_bit("bvalid_m1", 1'b1, bvalid);
    check_id("bid_m1", id, bid);
    check_resp("bresp_m1", resp, bresp);
  endtask

  task automatic outputs_idle();
    check_bit("rvalid_m0", 1'b0, rvalid[0]);
    check_bit("rvalid_m1", 1'b0, rvalid[1]);
    check_bit("bvalid_m1", 1'b0, bvalid);
    check_bit("arready_m0", 1'b0, arready[0]);
    check_bit("arready_m1", 1'b0, arready[1]);
    check_bit("awready_m1", 1'b0, awready);
    check_bit("wready_m1", 1'b0, wready);
  endtask

  task automatic read_txn(input int m, input logic [AXI_ID_BITS-1:0] id,
                          input logic [AXI_ADDR_BITS-1:0] addr,
                          input logic [AXI_DATA_BITS-1:0] exp_data, input logic [1:0] exp_resp);
    int                       cnt;
    int                       delay;
    logic [AXI_ID_BITS-1:0]   hold_id;
    logic [AXI_DATA_BITS-1:0] hold_data;
    logic [1:0]               hold_resp;
    arid[m]    = id;
    araddr[m]  = addr;
    arvalid[m] = 1'b1;
    cnt = 0;
    @(negedge clk);
    while (!arready[m]) begin
      cnt++;
      if (cnt > TIMEOUT)
        timed_out($sformatf("arready_m%0d", m));
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    arvalid[m] = 1'b0;
    // R is due one cycle after the AR transfer
    @(negedge clk);
    check_bit($sformatf("rvalid_m%0d", m), 1'b1, rvalid[m]);
    hold_id   = rid[m];
    hold_data = rdata[m];
    hold_resp = rresp[m];
    delay = $random(seed) & 3;
    repeat (delay) begin
      @(negedge clk);
      compare_r(m, hold_id, hold_data, hold_resp);
    end
    @(posedge clk);
    #1;
    rready[m] = 1'b1;
    @(negedge clk);
    compare_r(m, id, exp_data, exp_resp);
    @(posedge clk);
    #1;
    rready[m] = 1'b0;
  endtask

  task automatic write_txn(input logic [AXI_ID_BITS-1:0] id, input logic [AXI_ADDR_BITS-1:0] addr,
                           input logic [AXI_DATA_BITS-1:0] data,
                           input logic [AXI_STRB_BITS-1:0] strb, input logic [1:0] exp_resp);
    int                     cnt;
    int                     delay;
    logic [AXI_ID_BITS-1:0] hold_id;
    logic [1:0]             hold_resp;
    awid    = id;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    cnt = 0;
    @(negedge clk);
    while (!(awready && wready)) begin
      // AW and W are accepted together
      check_bit("awready_m1", 1'b0, awready);
      check_bit("wready_m1", 1'b0, wready);
      cnt++;
      if (cnt > TIMEOUT)
        timed_out("awready_m1 and wready_m1");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    cnt = 0;
    @(negedge clk);
    while (!bvalid) begin
      cnt++;
      if (cnt > TIMEOUT)
        timed_out("bvalid_m1");
      @(negedge clk);
    end
    hold_id   = bid;
    hold_resp = bresp;
    delay = $random(seed) & 3;
    repeat (delay) begin
      @(negedge clk);
      compare_b(hold_id, hold_resp);
    end
    @(posedge clk);
    #1;
    bready = 1'b1;
    @(negedge clk);
    compare_b(id, exp_resp);
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic run_line(input string line);
    logic [3:0]               op;
    logic [3:0]               m;
    logic [AXI_ID_BITS-1:0]   id;
    logic [AXI_ADDR_BITS-1:0] addr;
    logic [AXI_DATA_BITS-1:0] data;
    logic [AXI_STRB_BITS-1:0] strb;
    logic [AXI_DATA_BITS-1:0] exp_data;
    logic [1:0]               exp_resp;
    if ($sscanf(line, "%h %h %h %h %h %h %h %h", op, m, id, addr, data, strb, exp_data,
                exp_resp) != 8) begin
      $display("Malformed vector line: %s", line);
      abort_run();
    end
    if (op == 1 && m == 1) begin
      write_txn(id, addr, data, strb, exp_resp);
    end else if ((op == 0 || op == 2) && m <= 1) begin
      read_txn(int'(m), id, addr, exp_data, exp_resp);
    end else begin
      $display("Unsupported vector line: %s", line);
      abort_run();
    end
  endtask

  initial begin
    string      lines[$];
    string      line;
    int         fd;
    int         i;
    logic [3:0] op;
    logic [3:0] m_a;
    logic [3:0] m_b;
    seed      = 32'hb910_3476;
    arst_n    = 1'b0;
    arvalid   = 2'b00;
    rready    = 2'b00;
    arid[0]   = '0;
    arid[1]   = '0;
    araddr[0] = '0;
    araddr[1] = '0;
    awid      = '0;
    awaddr    = '0;
    wdata     = '0;
    wstrb     = '0;
    awvalid   = 1'b0;
    wvalid    = 1'b0;
    bready    = 1'b0;

    fd = $fopen("bench/top_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open bench/top_vectors.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.substr(0, 1) != "//")
        lines.push_back(line);
    end
    $fclose(fd);

    repeat (16) begin
      @(negedge clk);
      outputs_idle();
    end
    @(posedge clk);
    #1;
    arst_n = 1'b1;
    // Covers the synchronizer release and the first cycle after it
    repeat (4) begin
      @(negedge clk);
      outputs_idle();
    end

    i = 0;
    while (i < lines.size()) begin
      @(posedge clk);
      #1;
      void'($sscanf(lines[i], "%h %h", op, m_a));
      if (op == 2) begin
        if (i + 1 >= lines.size()) begin
          $display("Paired read on the last vector line has no partner");
          abort_run();
        end
        void'($sscanf(lines[i + 1], "%h %h", op, m_b));
        if (m_a == m_b) begin
          $display("Paired reads must come from different masters");
          abort_run();
        end
        fork
          run_line(lines[i]);
          run_line(lines[i + 1]);
        join
        i += 2;
      end else begin
        run_line(lines[i]);
        i++;
      end
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: bench/tb_top_assert.sv
`timescale 1ns/1ps

module tb_top_assert (
  input logic                              clk,
  input logic                              rst_n,
  input logic                              rvalid_m0,
  input logic                              rready_m0,
  input logic [axi_pkg::AXI_ID_BITS-1:0]   rid_m0,
  input logic [axi_pkg::AXI_DATA_BITS-1:0] rdata_m0,
  input logic [1:0]                        rresp_m0,
  input logic                              rvalid_m1,
  input logic                              rready_m1,
  input logic [axi_pkg::AXI_ID_BITS-1:0]   rid_m1,
  input logic [axi_pkg::AXI_DATA_BITS-1:0] rdata_m1,
  input logic [1:0]                        rresp_m1,
  input logic                              bvalid_m1,
  input logic                              bready_m1,
  input logic [axi_pkg::AXI_ID_BITS-1:0]   bid_m1,
  input logic [1:0]                        bresp_m1,
  input logic [1:0]                        slv_arvalid,
  input logic [1:0]                        slv_start,
  input logic [1:0]                        slv_done
);

  logic [1:0] pend_q;

  // Response owed by each slave, from its own handshakes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= 2'b00;
    end else begin
      pend_q <= (pend_q & ~slv_done) | slv_start;
    end
  end

  a_r_hold_m0: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_m0 && !rready_m0 |=> rvalid_m0 && $stable({rid_m0, rdata_m0, rresp_m0}))
    else $error("R to M0 dropped or changed before rready");

  a_r_hold_m1: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_m1 && !rready_m1 |=> rvalid_m1 && $stable({rid_m1, rdata_m1, rresp_m1}))
    else $error("R to M1 dropped or changed before rready");

  a_b_hold_m1: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid_m1 && !bready_m1 |=> bvalid_m1 && $stable({bid_m1, bresp_m1}))
    else $error("B to M1 dropped or changed before bready");

  // A slave that owes a response sees no new read
  a_no_ar_pending: assert property (@(posedge clk) disable iff (!rst_n)
    (slv_arvalid & pend_q) == 2'b00)
    else $error("slave arvalid raised while a response is pending");

endmodule

bind axi_xbar tb_top_assert u_assert (
  .*,
  .slv_arvalid ({s1.arvalid, s0.arvalid}),
  .slv_start   ({(s1.arvalid & s1.arready) | (s1.awvalid & s1.awready),
                 (s0.arvalid & s0.arready) | (s0.awvalid & s0.awready)}),
  .slv_done    ({(s1.rvalid & s1.rready) | (s1.bvalid & s1.bready),
                 (s0.rvalid & s0.rready) | (s0.bvalid & s0.bready)})
);

// File: bench/top_vectors.txt
// op master id addr data strb exp_data exp_resp, all hex
// op 0 read, 1 write (M1 only), 2 read started together with the next line
1 1 3 00010000 11223344 f 00000000 0
1 1 4 00010004 a5a5a5a5 f 00000000 0
1 1 5 00010000 deadbeef 5 00000000 0
1 1 6 00010004 01020304 a 00000000 0
0 1 7 00010000 00000000 0 11ad33ef 0
0 1 8 00010004 00000000 0 01a503a5 0
0 0 2 00010004 00000000 0 01a503a5 0
0 1 9 00011000 00000000 0 11ad33ef 0
1 1 a 00000040 cafef00d f 00000000 0
0 0 1 00000040 00000000 0 cafef00d 0
0 0 b 00020000 00000000 0 00000000 3
0 1 c 80000000 00000000 0 00000000 3
1 1 d 00030000 ffffffff f 00000000 3
1 1 e 00020040 ffffffff f 00000000 3
0 1 f 00010000 00000000 0 11ad33ef 0
0 0 0 00000040 00000000 0 cafef00d 0
2 0 6 00010004 00000000 0 01a503a5 0
0 1 7 00010000 00000000 0 11ad33ef 0
2 1 8 00000040 00000000 0 cafef00d 0
0 0 9 00000040 00000000 0 cafef00d 0
2 0 4 00040000 00000000 0 00000000 3
0 1 5 fffff000 00000000 0 00000000 3

// File: common/axi_if.sv
`timescale 1ns/1ps

interface axi_if;
  import axi_pkg::*;

  logic [AXI_IDS_BITS-1:0]  arid;
  logic [AXI_ADDR_BITS-1:0] araddr;
  logic                     arvalid;
  logic                     arready;

  logic [AXI_IDS_BITS-1:0]  rid;
  logic [AXI_DATA_BITS-1:0] rdata;
  logic [1:0]               rresp;
  logic                     rvalid;
  logic                     rready;

  logic [AXI_IDS_BITS-1:0]  awid;
  logic [AXI_ADDR_BITS-1:0] awaddr;
  logic                     awvalid;
  logic                     awready;

  logic [AXI_DATA_BITS-1:0] wdata;
  logic [AXI_STRB_BITS-1:0] wstrb;
  logic                     wvalid;
  logic                     wready;

  logic [AXI_IDS_BITS-1:0]  bid;
  logic [1:0]               bresp;
  logic                     bvalid;
  logic                     bready;

  modport master (
    output arid, araddr, arvalid, rready, awid, awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input  arready, rid, rdata, rresp, rvalid, awready, wready, bid, bresp, bvalid
  );

  modport slave (
    input  arid, araddr, arvalid, rready, awid, awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output arready, rid, rdata, rresp, rvalid, awready, wready, bid, bresp, bvalid
  );

endinterface

// File: common/axi_pkg.sv
package axi_pkg;

  // Master side and slave side ID widths
  localparam int AXI_ID_BITS   = 4;
  localparam int AXI_IDS_BITS  = 8;

  localparam int AXI_ADDR_BITS = 32;
  localparam int AXI_DATA_BITS = 32;
  localparam int AXI_STRB_BITS = AXI_DATA_BITS / 8;

  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_DECERR = 2'b11;

  // Address map, 64 KiB per region
  localparam int REGION_BITS = 16;
  localparam logic [AXI_ADDR_BITS-1:0] IM_BASE = 32'h0000_0000;
  localparam logic [AXI_ADDR_BITS-1:0] DM_BASE = 32'h0001_0000;

endpackage

// File: project.f
common/axi_pkg.sv
common/axi_if.sv
source/reset_sync.sv
axi/axi_xbar.sv
sram/sram_wrapper.sv
source/top.sv
bench/tb_top_assert.sv
bench/tb_top.sv

// File: source/reset_sync.sv
`timescale 1ns/1ps

module reset_sync (
  input  logic clk,
  input  logic arst_n,
  output logic rst_n_sync
);

  logic [1:0] sync_q;

  // Assert at once, release after two edges
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_n_sync = sync_q[1];

endmodule

// File: source/top.sv
`timescale 1ns/1ps

module top #(
  parameter int IM_WORDS = 1024,
  parameter int DM_WORDS = 1024
) (
  input  logic                              clk,
  input  logic                              arst_n,
  // M0 fetch port
  input  logic [axi_pkg::AXI_ID_BITS-1:0]   arid_m0,
  input  logic [axi_pkg::AXI_ADDR_BITS-1:0] araddr_m0,
  input  logic                              arvalid_m0,
  output logic                              arready_m0,
  output logic [axi_pkg::AXI_ID_BITS-1:0]   rid_m0,
  output logic [axi_pkg::AXI_DATA_BITS-1:0] rdata_m0,
  output logic [1:0]                        rresp_m0,
  output logic                              rvalid_m0,
  input  logic                              rready_m0,
  // M1 load/store port
  input  logic [axi_pkg::AXI_ID_BITS-1:0]   arid_m1,
  input  logic [axi_pkg::AXI_ADDR_BITS-1:0] araddr_m1,
  input  logic                              arvalid_m1,
  output logic                              arready_m1,
  output logic [axi_pkg::AXI_ID_BITS-1:0]   rid_m1,
  output logic [axi_pkg::AXI_DATA_BITS-1:0] rdata_m1,
  output logic [1:0]                        rresp_m1,
  output logic                              rvalid_m1,
  input  logic                              rready_m1,
  input  logic [axi_pkg::AXI_ID_BITS-1:0]   awid_m1,
  input  logic [axi_pkg::AXI_ADDR_BITS-1:0] awaddr_m1,
  input  logic                              awvalid_m1,
  output logic                              awready_m1,
  input  logic [axi_pkg::AXI_DATA_BITS-1:0] wdata_m1,
  input  logic [axi_pkg::AXI_STRB_BITS-1:0] wstrb_m1,
  input  logic                              wvalid_m1,
  output logic                              wready_m1,
  output logic [axi_pkg::AXI_ID_BITS-1:0]   bid_m1,
  output logic [1:0]                        bresp_m1,
  output logic                              bvalid_m1,
  input  logic                              bready_m1
);

  logic rst_n;

  axi_if im_bus ();
  axi_if dm_bus ();

  reset_sync u_reset_sync (
    .clk        (clk),
    .arst_n     (arst_n),
    .rst_n_sync (rst_n)
  );

  // Master ports match by name
  axi_xbar u_xbar (
    .s0 (im_bus),
    .s1 (dm_bus),
    .*
  );

  sram_wrapper #(.MEM_WORDS(IM_WORDS)) u_im (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (im_bus)
  );

  sram_wrapper #(.MEM_WORDS(DM_WORDS)) u_dm (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (dm_bus)
  );

endmodule

// File: sram/sram_wrapper.sv
`timescale 1ns/1ps

module sram_wrapper #(
  parameter int MEM_WORDS = 1024
) (
  input  logic  clk,
  input  logic  rst_n,
  axi_if.slave  bus
);
  import axi_pkg::*;

  localparam int IDX_BITS = $clog2(MEM_WORDS);

  logic [AXI_DATA_BITS-1:0] mem [MEM_WORDS];
  logic                     idle;
  logic                     rd_go;
  logic                     wr_go;
  logic [IDX_BITS-1:0]      rd_idx;
  logic [IDX_BITS-1:0]      wr_idx;
  logic                     rvalid_q;
  logic                     bvalid_q;
  logic [AXI_IDS_BITS-1:0]  rid_q;
  logic [AXI_IDS_BITS-1:0]  bid_q;
  logic [AXI_DATA_BITS-1:0] rdata_q;

  // One response outstanding at most
  assign idle  = ~rvalid_q & ~bvalid_q;
  assign rd_go = idle & bus.arvalid;
  // Read wins a same-cycle tie
  assign wr_go = idle & ~bus.arvalid & bus.awvalid & bus.wvalid;

  // Word index wraps inside the region
  assign rd_idx = IDX_BITS'((bus.araddr >> 2) % MEM_WORDS);
  assign wr_idx = IDX_BITS'((bus.awaddr >> 2) % MEM_WORDS);

  assign bus.arready = idle;
  assign bus.awready = wr_go;
  assign bus.wready  = wr_go;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (rd_go)
        rvalid_q <= 1'b1;
      else if (bus.rready)
        rvalid_q <= 1'b0;
      if (wr_go)
        bvalid_q <= 1'b1;
      else if (bus.bready)
        bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_go) begin
      rid_q   <= bus.arid;
      rdata_q <= mem[rd_idx];
    end
    if (wr_go) begin
      bid_q <= bus.awid;
      for (int b = 0; b < AXI_STRB_BITS; b++) begin
        if (bus.wstrb[b])
          mem[wr_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
      end
    end
  end

  assign bus.rid    = rid_q;
  assign bus.rdata  = rdata_q;
  assign bus.rresp  = AXI_RESP_OKAY;
  assign bus.rvalid = rvalid_q;
  assign bus.bid    = bid_q;
  assign bus.bresp  = AXI_RESP_OKAY;
  assign bus.bvalid = bvalid_q;

endmodule
